//--- chdr_pkg.sv
/*
 * CHDR receive path definitions.
 * Line and word widths, header field positions, FIFO sizing
 * and the deframer state encoding.
 */
package chdr_pkg;

   // Stream widths.
   localparam int CHDR_W  = 64;   // Input line.
   localparam int ITEM_W  = 32;   // Output word.
   localparam int TUSER_W = 128;  // Header and timestamp sideband.

   // Header field widths.
   localparam int SEQ_W = 12;
   localparam int LEN_W = 16;

   // Field positions within the header line.
   localparam int HAS_TIME_BIT = 61;
   localparam int EOB_BIT      = 60;
   localparam int SEQ_LSB      = 48;
   localparam int LEN_LSB      = 32;  // Bytes, header and timestamp included.
   localparam int SID_LSB      = 0;

   // Width of the sequence gap counter.
   localparam int ERR_CNT_W = 16;

   // FIFO depths as log2.
   localparam int HDR_FIFO_SIZE  = 5;
   localparam int BODY_FIFO_SIZE = 5;

   /* Deframer line routing.
      Header, then optional timestamp, then body lines up to tlast. */
   typedef enum logic [1:0] {
      ST_HEAD,
      ST_TIME,
      ST_BODY
   } deframe_state_t;

endpackage

//--- axis_fifo.sv
`timescale 1ns/1ps
/*
 * Synchronous AXI-stream FIFO with a registered output stage.
 * A beat written into an empty FIFO is valid at the output the next cycle.
 */
module axis_fifo #(
   parameter int WIDTH = 32,
   parameter int SIZE  = 5
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_clear,
   input  logic [WIDTH-1:0] i_tdata,
   input  logic             i_tvalid,
   output logic             i_tready,
   output logic [WIDTH-1:0] o_tdata,
   output logic             o_tvalid,
   input  logic             o_tready
);
   localparam int DEPTH = 2 ** SIZE;

   logic [WIDTH-1:0] mem [0:DEPTH-1];
   logic [SIZE-1:0]  wr_ptr;
   logic [SIZE-1:0]  rd_ptr;
   logic [SIZE-1:0]  wr_ptr_nxt;
   logic [SIZE-1:0]  rd_ptr_nxt;
   logic             full;
   logic             empty;
   logic             out_valid;
   logic [WIDTH-1:0] out_data;
   logic             push;
   logic             pop;
   logic             out_free;
   logic             bypass;
   logic             mem_wr;
   logic             mem_rd;

   assign i_tready = !full;
   assign o_tvalid = out_valid;
   assign o_tdata  = out_data;

   assign push     = i_tvalid && !full;
   assign pop      = out_valid && o_tready;
   assign out_free = !out_valid || pop;
   assign bypass   = push && empty && out_free;  // Straight into the output stage.
   assign mem_wr   = push && !bypass;
   assign mem_rd   = !empty && out_free;

   assign wr_ptr_nxt = wr_ptr + 1'b1;
   assign rd_ptr_nxt = rd_ptr + 1'b1;

   always_ff @(posedge clk)
   begin
      if (!i_rst_n || i_clear)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         full      <= 1'b0;
         empty     <= 1'b1;
         out_valid <= 1'b0;
      end
      else
      begin
         if (mem_wr)
            wr_ptr <= wr_ptr_nxt;
         if (mem_rd)
            rd_ptr <= rd_ptr_nxt;

         if (mem_wr && !mem_rd)
         begin
            empty <= 1'b0;
            full  <= (wr_ptr_nxt == rd_ptr);
         end
         else if (mem_rd && !mem_wr)
         begin
            full  <= 1'b0;
            empty <= (rd_ptr_nxt == wr_ptr);
         end

         if (mem_rd || bypass)
            out_valid <= 1'b1;
         else if (pop)
            out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (mem_wr)
         mem[wr_ptr] <= i_tdata;
      if (mem_rd)
         out_data <= mem[rd_ptr];  // Oldest stored beat first.
      else if (bypass)
         out_data <= i_tdata;
   end

endmodule

//--- chdr_deframer.sv
`timescale 1ns/1ps
/*
 * CHDR deframer.
 * Moves header and timestamp into a 128-bit sideband held for the whole packet
 * and narrows 64-bit body lines to 32-bit words, upper half first.
 */
module chdr_deframer (
   input  logic                         clk,
   input  logic                         i_rst_n,
   input  logic                         i_clear,
   input  logic [chdr_pkg::CHDR_W-1:0]  i_tdata,
   input  logic                         i_tlast,
   input  logic                         i_tvalid,
   output logic                         i_tready,
   output logic [chdr_pkg::ITEM_W-1:0]  o_tdata,
   output logic [chdr_pkg::TUSER_W-1:0] o_tuser,
   output logic                         o_tlast,
   output logic                         o_tvalid,
   input  logic                         o_tready
);
   import chdr_pkg::*;

   deframe_state_t    state;
   logic [CHDR_W-1:0] held_hdr;
   logic              has_time;
   logic              in_xfer;

   // Header FIFO side.
   logic [TUSER_W-1:0] hdr_in_tuser;
   logic               hdr_in_tvalid;
   logic               hdr_in_tready;
   logic [TUSER_W-1:0] hdr_out_tuser;
   logic               hdr_out_tvalid;
   logic               hdr_out_tready;

   // Body FIFO side, last flag on top of the line.
   logic [CHDR_W:0]   body_in_tdata;
   logic              body_in_tvalid;
   logic              body_in_tready;
   logic [CHDR_W:0]   body_out_tdata;
   logic              body_out_tvalid;
   logic              body_out_tready;
   logic [CHDR_W-1:0] body_line;
   logic              body_last;

   // Output narrowing.
   logic             half_sel;
   logic [LEN_W-1:0] pkt_len;
   logic             one_word;
   logic             last_word;
   logic             out_valid;
   logic             out_xfer;

   assign has_time = i_tdata[HAS_TIME_BIT];
   assign in_xfer  = i_tvalid && i_tready;

   // Without a timestamp the header fills both halves.
   assign hdr_in_tuser  = (state == ST_HEAD) ? {i_tdata, i_tdata} : {held_hdr, i_tdata};
   assign hdr_in_tvalid = i_tvalid &&
                          ((state == ST_TIME) || ((state == ST_HEAD) && !has_time));

   assign body_in_tdata  = {i_tlast, i_tdata};
   assign body_in_tvalid = i_tvalid && (state == ST_BODY);

   assign i_tready = (state == ST_BODY) ? body_in_tready : hdr_in_tready;

   always_ff @(posedge clk)
   begin
      if (!i_rst_n || i_clear)
         state <= ST_HEAD;
      else if (in_xfer)
      begin
         case (state)
            ST_HEAD: state <= has_time ? ST_TIME : ST_BODY;
            ST_TIME: state <= ST_BODY;
            ST_BODY:
            begin
               if (i_tlast)
                  state <= ST_HEAD;
            end
            default: state <= ST_HEAD;
         endcase
      end
   end

   // Header waits here for its timestamp.
   always_ff @(posedge clk)
   begin
      if ((state == ST_HEAD) && in_xfer)
         held_hdr <= i_tdata;
   end

   axis_fifo #(
      .WIDTH (TUSER_W),
      .SIZE  (HDR_FIFO_SIZE)
   ) u_hdr_fifo (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_clear  (i_clear),
      .i_tdata  (hdr_in_tuser),
      .i_tvalid (hdr_in_tvalid),
      .i_tready (hdr_in_tready),
      .o_tdata  (hdr_out_tuser),
      .o_tvalid (hdr_out_tvalid),
      .o_tready (hdr_out_tready)
   );

   axis_fifo #(
      .WIDTH (CHDR_W + 1),
      .SIZE  (BODY_FIFO_SIZE)
   ) u_body_fifo (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_clear  (i_clear),
      .i_tdata  (body_in_tdata),
      .i_tvalid (body_in_tvalid),
      .i_tready (body_in_tready),
      .o_tdata  (body_out_tdata),
      .o_tvalid (body_out_tvalid),
      .o_tready (body_out_tready)
   );

   assign body_line = body_out_tdata[CHDR_W-1:0];
   assign body_last = body_out_tdata[CHDR_W];

   // Length from the header half of the sideband.
   assign pkt_len  = hdr_out_tuser[CHDR_W + LEN_LSB +: LEN_W];
   assign one_word = (pkt_len[2:0] != 3'd0) && (pkt_len[2:0] <= 3'd4);  // Last line half used.

   assign out_valid = hdr_out_tvalid && body_out_tvalid;
   assign last_word = body_last && (half_sel || one_word);
   assign out_xfer  = out_valid && o_tready;

   always_ff @(posedge clk)
   begin
      if (!i_rst_n || i_clear)
         half_sel <= 1'b0;
      else if (out_xfer)
         half_sel <= last_word ? 1'b0 : !half_sel;
   end

   assign body_out_tready = out_xfer && (half_sel || last_word);
   assign hdr_out_tready  = out_xfer && last_word;

   assign o_tdata  = half_sel ? body_line[ITEM_W-1:0] : body_line[CHDR_W-1:ITEM_W];
   assign o_tuser  = hdr_out_tuser;
   assign o_tlast  = last_word;
   assign o_tvalid = out_valid;

endmodule

//--- chdr_seq_monitor.sv
`timescale 1ns/1ps
/*
 * CHDR sequence monitor.
 * Checks that each delivered packet carries the previous sequence number plus one
 * and counts the gaps.
 */
module chdr_seq_monitor (
   input  logic                            clk,
   input  logic                            i_rst_n,
   input  logic                            i_clear,
   input  logic [chdr_pkg::TUSER_W-1:0]    i_tuser,
   input  logic                            i_tvalid,
   input  logic                            i_tready,
   input  logic                            i_tlast,
   output logic                            o_seq_err,
   output logic [chdr_pkg::ERR_CNT_W-1:0]  o_seq_err_count
);
   import chdr_pkg::*;

   logic                 xfer;
   logic                 sop;         // Next transfer starts a packet.
   logic                 seen_first;
   logic [SEQ_W-1:0]     pkt_seq;
   logic [SEQ_W-1:0]     prev_seq;
   logic [SEQ_W-1:0]     exp_seq;
   logic                 gap;
   logic [ERR_CNT_W-1:0] err_count;
   logic                 seq_err;

   assign xfer    = i_tvalid && i_tready;
   assign pkt_seq = i_tuser[CHDR_W + SEQ_LSB +: SEQ_W];
   assign exp_seq = prev_seq + 1'b1;  // Wraps at 4096.
   assign gap     = seen_first && (pkt_seq != exp_seq);

   always_ff @(posedge clk)
   begin
      if (!i_rst_n || i_clear)
      begin
         sop        <= 1'b1;
         seen_first <= 1'b0;
         seq_err    <= 1'b0;
         err_count  <= '0;
      end
      else
      begin
         seq_err <= 1'b0;
         if (xfer)
            sop <= i_tlast;
         if (xfer && sop)
         begin
            seen_first <= 1'b1;
            if (gap)
            begin
               seq_err <= 1'b1;
               if (err_count != {ERR_CNT_W{1'b1}})
                  err_count <= err_count + 1'b1;  // Saturates.
            end
         end
      end
   end

   // Sequence number of the last packet start.
   always_ff @(posedge clk)
   begin
      if (xfer && sop)
         prev_seq <= pkt_seq;
   end

   assign o_seq_err       = seq_err;
   assign o_seq_err_count = err_count;

endmodule

//--- chdr_rx_top.sv
`timescale 1ns/1ps
/*
 * CHDR receive top.
 * Deframer with a sequence monitor watching its output stream.
 */
module chdr_rx_top (
   input  logic                            clk,
   input  logic                            i_rst_n,
   input  logic                            i_clear,

   // CHDR line input.
   input  logic [chdr_pkg::CHDR_W-1:0]     i_tdata,
   input  logic                            i_tlast,
   input  logic                            i_tvalid,
   output logic                            i_tready,

   // Body word output with header sideband.
   output logic [chdr_pkg::ITEM_W-1:0]     o_tdata,
   output logic [chdr_pkg::TUSER_W-1:0]    o_tuser,
   output logic                            o_tlast,
   output logic                            o_tvalid,
   input  logic                            o_tready,

   // Sequence status.
   output logic                            o_seq_err,
   output logic [chdr_pkg::ERR_CNT_W-1:0]  o_seq_err_count
);

   chdr_deframer u_deframer (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_clear  (i_clear),
      .i_tdata  (i_tdata),
      .i_tlast  (i_tlast),
      .i_tvalid (i_tvalid),
      .i_tready (i_tready),
      .o_tdata  (o_tdata),
      .o_tuser  (o_tuser),
      .o_tlast  (o_tlast),
      .o_tvalid (o_tvalid),
      .o_tready (o_tready)
   );

   // Sees exactly the transfers leaving the top.
   chdr_seq_monitor u_seq_monitor (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_clear         (i_clear),
      .i_tuser         (o_tuser),
      .i_tvalid        (o_tvalid),
      .i_tready        (o_tready),
      .i_tlast         (o_tlast),
      .o_seq_err       (o_seq_err),
      .o_seq_err_count (o_seq_err_count)
   );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps
/*
 * Testbench clock and reset.
 * 100 ns clock, reset held low for the first four cycles.
 */
module tb_clkgen (
   output logic clk,
   output logic o_rst_n
);

   initial
   begin
      clk     = 1'b0;
      o_rst_n = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      o_rst_n = 1'b1;
   end

   always #50 clk = ~clk;

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps
/*
 * Output checker.
 * Compares every output transfer with the queued expected words and
 * tracks the expected sequence error pulse and gap count.
 */
module tb_checker (
   input logic                           clk,
   input logic                           i_rst_n,
   input logic                           i_clear,
   input logic [chdr_pkg::ITEM_W-1:0]    i_tdata,
   input logic [chdr_pkg::TUSER_W-1:0]   i_tuser,
   input logic                           i_tlast,
   input logic                           i_tvalid,
   input logic                           i_tready,
   input logic                           i_seq_err,
   input logic [chdr_pkg::ERR_CNT_W-1:0] i_seq_err_count
);
   import chdr_pkg::*;

   logic [ITEM_W-1:0]    exp_data [$];
   logic [TUSER_W-1:0]   exp_user [$];
   logic                 exp_last [$];
   int                   error_count = 0;
   logic                 sop = 1'b1;
   logic                 seen_first = 1'b0;
   logic                 err_due = 1'b0;
   logic [ERR_CNT_W-1:0] exp_count = '0;
   logic [SEQ_W-1:0]     last_seq;
   logic [SEQ_W-1:0]     want_seq;
   logic [SEQ_W-1:0]     seq;
   logic [ITEM_W-1:0]    d;
   logic [TUSER_W-1:0]   u;
   logic                 l;

   task automatic expect_beat(input logic [ITEM_W-1:0] data, input logic [TUSER_W-1:0] user,
                              input logic last);
      exp_data.push_back(data);
      exp_user.push_back(user);
      exp_last.push_back(last);
   endtask

   function automatic int pending();
      return exp_data.size();
   endfunction

   always @(posedge clk)
   begin
      if (i_rst_n && !i_clear)
      begin
         if (i_seq_err !== err_due)
         begin
            $display("ERROR at %0t ns: o_seq_err is %b, expected %b", $time, i_seq_err, err_due);
            error_count++;
         end
         if (i_seq_err_count !== exp_count)
         begin
            $display("ERROR at %0t ns: o_seq_err_count is %0d, expected %0d",
                     $time, i_seq_err_count, exp_count);
            error_count++;
         end
      end
      err_due = 1'b0;

      if (!i_rst_n || i_clear)
      begin
         sop        = 1'b1;
         seen_first = 1'b0;
         exp_count  = '0;
      end
      else if (i_tvalid && i_tready)
      begin
         if (exp_data.size() == 0)
         begin
            $display("Output word at %0t ns arrived while no word was expected", $time);
            error_count++;
         end
         else
         begin
            d = exp_data.pop_front();
            u = exp_user.pop_front();
            l = exp_last.pop_front();
            if (i_tdata !== d || i_tuser !== u || i_tlast !== l)
            begin
               $display("ERROR at %0t ns: word %h last %b user %h, expected %h %b %h",
                        $time, i_tdata, i_tlast, i_tuser, d, l, u);
               error_count++;
            end
         end

         // Sequence rule on the first word of each packet.
         if (sop)
         begin
            seq      = i_tuser[CHDR_W + SEQ_LSB +: SEQ_W];
            want_seq = last_seq + 1'b1;
            if (seen_first && seq != want_seq)
            begin
               err_due   = 1'b1;
               exp_count = exp_count + 1'b1;
            end
            seen_first = 1'b1;
            last_seq   = seq;
         end
         sop = i_tlast;
      end
   end

endmodule

//--- tb_chdr_rx.sv
`timescale 1ns/1ps
/*
 * CHDR receive testbench.
 * Sends CHDR packets into the receive top and queues the expected words.
 */
module tb_chdr_rx;
   import chdr_pkg::*;

   localparam int WAIT_LIMIT = 2000;

   logic                 clk;
   logic                 rst_n;
   logic                 clear;
   logic [CHDR_W-1:0]    in_data;
   logic                 in_last;
   logic                 in_valid;
   logic                 in_ready;
   logic [ITEM_W-1:0]    out_data;
   logic [TUSER_W-1:0]   out_user;
   logic                 out_last;
   logic                 out_valid;
   logic                 out_ready;
   logic                 seq_err;
   logic [ERR_CNT_W-1:0] err_cnt;

   logic             backpressure;
   logic             gaps_on;
   logic             timed_out;
   logic [SEQ_W-1:0] next_seq;
   int               own_errors;
   int               errors_before;
   int               tests_passed;
   int               tests_failed;
   int               seed;

   tb_clkgen u_clkgen (.clk(clk), .o_rst_n(rst_n));

   chdr_rx_top u_dut (
      .clk             (clk),
      .i_rst_n         (rst_n),
      .i_clear         (clear),
      .i_tdata         (in_data),
      .i_tlast         (in_last),
      .i_tvalid        (in_valid),
      .i_tready        (in_ready),
      .o_tdata         (out_data),
      .o_tuser         (out_user),
      .o_tlast         (out_last),
      .o_tvalid        (out_valid),
      .o_tready        (out_ready),
      .o_seq_err       (seq_err),
      .o_seq_err_count (err_cnt)
   );

   tb_checker u_checker (
      .clk             (clk),
      .i_rst_n         (rst_n),
      .i_clear         (clear),
      .i_tdata         (out_data),
      .i_tuser         (out_user),
      .i_tlast         (out_last),
      .i_tvalid        (out_valid),
      .i_tready        (out_ready),
      .i_seq_err       (seq_err),
      .i_seq_err_count (err_cnt)
   );

   always @(negedge clk)
      out_ready = backpressure ? (($urandom % 4) != 0) : 1'b1;

   // Sideband layout, header on top, timestamp or header again below.
   function automatic logic [TUSER_W-1:0] ref_sideband(input logic [CHDR_W-1:0] hdr,
                                                       input logic [CHDR_W-1:0] ts);
      return hdr[HAS_TIME_BIT] ? {hdr, ts} : {hdr, hdr};
   endfunction

   function automatic int ref_word_count(input logic [CHDR_W-1:0] hdr);
      int body_bytes;
      body_bytes = hdr[LEN_LSB +: LEN_W] - (hdr[HAS_TIME_BIT] ? 16 : 8);
      return (body_bytes + 3) / 4;  // Partial word still counts.
   endfunction

   task automatic send_line(input logic [CHDR_W-1:0] data, input logic last);
      int   waited;
      int   n_idle;
      logic taken;
      waited = 0;
      taken  = 1'b0;
      n_idle = gaps_on ? ($urandom % 3) : 0;
      repeat (n_idle)
      begin
         @(negedge clk);
         in_valid = 1'b0;
      end
      while (!taken && !timed_out)
      begin
         @(negedge clk);
         in_valid = 1'b1;
         in_data  = data;
         in_last  = last;
         taken    = in_ready;  // Ready only moves on clock edges.
         @(posedge clk);
         waited++;
         if (waited > WAIT_LIMIT)
         begin
            $display("Timeout: i_tready stayed low while sending an input line");
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic send_packet(input logic [SEQ_W-1:0] seq, input logic has_time,
                              input int lines, input logic odd);
      logic [CHDR_W-1:0]  hdr;
      logic [CHDR_W-1:0]  ts;
      logic [CHDR_W-1:0]  body [0:7];
      logic [TUSER_W-1:0] user;
      logic [ITEM_W-1:0]  word;
      int                 n;
      hdr                          = '0;
      hdr[HAS_TIME_BIT]            = has_time;
      hdr[EOB_BIT]                 = $urandom % 2;
      hdr[SEQ_LSB +: SEQ_W]        = seq;
      hdr[LEN_LSB +: LEN_W]        = (has_time ? 16 : 8) + 8 * lines - (odd ? 4 : 0);
      hdr[SID_LSB +: 16]           = $urandom;
      ts                           = {$urandom, $urandom};
      for (int i = 0; i < lines; i++)
         body[i] = {$urandom, $urandom};

      user = ref_sideband(hdr, ts);
      n    = ref_word_count(hdr);
      for (int k = 0; k < n; k++)
      begin
         word = k[0] ? body[k / 2][ITEM_W-1:0] : body[k / 2][CHDR_W-1:ITEM_W];
         u_checker.expect_beat(word, user, k == n - 1);
      end

      send_line(hdr, 1'b0);
      if (has_time)
         send_line(ts, 1'b0);
      for (int i = 0; i < lines; i++)
         send_line(body[i], i == lines - 1);
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic drain_outputs();
      int waited;
      waited = 0;
      while (u_checker.pending() != 0 && !timed_out)
      begin
         @(negedge clk);
         waited++;
         if (waited > WAIT_LIMIT)
         begin
            $display("Timeout: expected output words were never delivered");
            timed_out = 1'b1;
         end
      end
      @(negedge clk);  // Lets a late count update settle.
   endtask

   task automatic finish_test(input string name);
      int errs;
      drain_outputs();
      errs = u_checker.error_count + own_errors;
      if (errs == errors_before && !timed_out)
      begin
         tests_passed++;
         $display("Test %s: passed", name);
      end
      else
      begin
         tests_failed++;
         $display("Test %s: failed", name);
      end
      errors_before = errs;
   endtask

   task automatic check_count(input int expected);
      if (err_cnt !== expected)
      begin
         $display("ERROR at %0t ns: gap count %0d, expected %0d", $time, err_cnt, expected);
         own_errors++;
      end
   endtask

   // Both FIFOs empty, so the input is ready and nothing is offered.
   task automatic check_idle(input string cause);
      if (in_ready !== 1'b1 || out_valid !== 1'b0)
      begin
         $display("ERROR at %0t ns: after %s i_tready %b o_tvalid %b, expected 1 and 0",
                  $time, cause, in_ready, out_valid);
         own_errors++;
      end
   endtask

   initial
   begin
      seed          = $urandom(32'hf35a);
      in_data       = '0;
      in_last       = 1'b0;
      in_valid      = 1'b0;
      out_ready     = 1'b1;
      clear         = 1'b0;
      backpressure  = 1'b0;
      gaps_on       = 1'b0;
      timed_out     = 1'b0;
      own_errors    = 0;
      errors_before = 0;
      tests_passed  = 0;
      tests_failed  = 0;
      next_seq      = 12'd100;

      for (int w = 0; w <= WAIT_LIMIT && rst_n !== 1'b1; w++)
         @(negedge clk);
      if (rst_n !== 1'b1)
      begin
         $display("Timeout: reset was never released");
         timed_out = 1'b1;
      end
      @(negedge clk);
      check_idle("reset");

      for (int i = 0; i < 4; i++)
      begin
         send_packet(next_seq, 1'b1, 1 + i, 1'b0);
         next_seq++;
      end
      finish_test("timestamp, even length");

      for (int i = 0; i < 4; i++)
      begin
         send_packet(next_seq, 1'b0, 1 + i, 1'b1);
         next_seq++;
      end
      finish_test("no timestamp, length 4 mod 8");

      backpressure = 1'b1;
      gaps_on      = 1'b1;
      for (int i = 0; i < 40; i++)
      begin
         send_packet(next_seq, $urandom % 2, 1 + ($urandom % 6), $urandom % 2);
         next_seq++;
      end
      finish_test("random gaps and back-pressure");
      backpressure = 1'b0;
      gaps_on      = 1'b0;

      // Jump to 4094 and wrap to 0, then two skipped numbers, three gaps in all.
      next_seq = 12'd4094;
      for (int i = 0; i < 4; i++)
      begin
         send_packet(next_seq, $urandom % 2, 2, 1'b0);
         next_seq++;
      end
      send_packet(12'd3, 1'b0, 1, 1'b1);
      send_packet(12'd4, 1'b1, 2, 1'b0);
      send_packet(12'd10, 1'b0, 3, 1'b0);
      send_packet(12'd11, 1'b1, 1, 1'b1);
      drain_outputs();
      check_count(3);
      finish_test("sequence gaps");

      @(negedge clk);
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
      check_count(0);
      check_idle("clear");
      next_seq = $urandom;
      send_packet(next_seq, 1'b1, 2, 1'b1);
      send_packet(next_seq + 1'b1, 1'b0, 2, 1'b0);
      drain_outputs();
      check_count(0);
      finish_test("clear between packets");

      $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && !timed_out)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- filelist.f
chdr_pkg.sv
axis_fifo.sv
chdr_deframer.sv
chdr_seq_monitor.sv
chdr_rx_top.sv
tb_clkgen.sv
tb_checker.sv
tb_chdr_rx.sv
